// File: logic/cpuBusCombiner.sv
`timescale 1ns/1ps
`default_nettype none
`include "dataCtrl_defines.svh"

module cpuBusCombiner import dataCtrlPkg::*; (
	input wire cpuBus_s bus,
	input wire cpuWord_t viaData,
	input wire regByte_t sccData,
	input wire cpuWord_t memoryDataIn,
	input wire irqLines_s irq,
	output cpuWord_t cpuDataOut,
	output cpuWord_t memoryDataOut,
	output ipl_t cpuIPL
);

	// VIA first, then SCC, otherwise memory
	always_comb begin
		if (bus.viaSel) begin
			cpuDataOut = viaData;
		end else if (bus.sccSel) begin
			// SCC drives only the upper lane
			cpuDataOut = {sccData, `BUS_PAD_BYTE};
		end else begin
			cpuDataOut = memoryDataIn;
		end
	end

	assign memoryDataOut = bus.dataIn;

	// VIA on level 1, SCC on level 2, both inverted
	always_comb begin
		if (!irq.viaIrqN) begin
			cpuIPL = 3'b110;
		end else if (!irq.sccIrqN) begin
			cpuIPL = 3'b101;
		end else begin
			cpuIPL = 3'b111;
		end
	end

	// address decode upstream must keep the selects exclusive
	always_comb begin
		selectsExclusive: assert final (!(bus.viaSel && bus.sccSel))
			else $error("VIA and SCC selected together");
	end

endmodule

`default_nettype wire

// File: logic/dataController.sv
`timescale 1ns/1ps
`default_nettype none

module dataController import dataCtrlPkg::*; (
	input wire clk8,
	input wire _systemReset,
	output logic _cpuReset,
	output ipl_t _cpuIPL,
	input wire cpuWord_t cpuDataIn,
	input wire viaRegSel_t cpuAddrRegHi,
	input wire sccRegSel_t cpuAddrRegLo,
	input wire _cpuUDS,
	input wire _cpuLDS,
	input wire _cpuRW,
	output cpuWord_t cpuDataOut,
	input wire selectVIA,
	input wire selectSCC,
	input wire cpuBusControl,
	input wire cpuWord_t memoryDataIn,
	output cpuWord_t memoryDataOut,
	input wire loadSound,
	input wire _vblank,
	input wire _hblank,
	input wire mouseX1,
	input wire mouseY1,
	output audioWord_t audioOut,
	output logic sndAlt,
	output logic memoryOverlayOn
);

	logic cpuResetN;
	cpuBus_s cpuBus;
	soundCtrl_s soundCtrl;
	irqLines_s irqLines;
	cpuWord_t viaData;
	regByte_t sccData;

	// selects only count while the CPU owns the bus
	assign cpuBus.viaSel = selectVIA && cpuBusControl;
	assign cpuBus.sccSel = selectSCC && cpuBusControl;
	assign cpuBus.dataIn = cpuDataIn;
	assign cpuBus.rwN = _cpuRW;
	assign cpuBus.udsN = _cpuUDS;
	assign cpuBus.ldsN = _cpuLDS;

	assign _cpuReset = cpuResetN;

	resetSequencer u_resetSequencer (
		.clk8(clk8),
		._systemReset(_systemReset),
		.cpuResetN(cpuResetN)
	);

	// peripherals come out of reset together with the CPU
	viaRegs u_viaRegs (
		.clk8(clk8),
		._systemReset(cpuResetN),
		.bus(cpuBus),
		.regSel(cpuAddrRegHi),
		._vblank(_vblank),
		._hblank(_hblank),
		.dataOut(viaData),
		.irqN(irqLines.viaIrqN),
		.sound(soundCtrl),
		.memoryOverlayOn(memoryOverlayOn)
	);

	// mouse quadrature on the DCD inputs
	sccIrq u_sccIrq (
		.clk8(clk8),
		.cpuResetN(cpuResetN),
		.bus(cpuBus),
		.regSel(cpuAddrRegLo),
		.dcdA(mouseX1),
		.dcdB(mouseY1),
		.dataOut(sccData),
		.irqN(irqLines.sccIrqN)
	);

	soundMixer u_soundMixer (
		.clk8(clk8),
		.cpuResetN(cpuResetN),
		.loadSound(loadSound),
		.sampleByte(memoryDataIn[15:8]),
		.sound(soundCtrl),
		.audioOut(audioOut),
		.sndAlt(sndAlt)
	);

	cpuBusCombiner u_cpuBusCombiner (
		.bus(cpuBus),
		.viaData(viaData),
		.sccData(sccData),
		.memoryDataIn(memoryDataIn),
		.irq(irqLines),
		.cpuDataOut(cpuDataOut),
		.memoryDataOut(memoryDataOut),
		.cpuIPL(_cpuIPL)
	);

endmodule

`default_nettype wire

// File: logic/dataCtrlPkg.sv
`default_nettype none

package dataCtrlPkg;

	typedef logic [15:0] cpuWord_t;
	typedef logic [7:0] regByte_t;
	typedef logic [3:0] viaRegSel_t;
	typedef logic [1:0] sccRegSel_t;
	// active low, 3'b111 means no request
	typedef logic [2:0] ipl_t;
	typedef logic [2:0] volume_t;
	typedef logic [10:0] audioWord_t;
	typedef logic [19:0] resetCount_t;

	// decoded CPU access, selects already qualified with bus control
	typedef struct packed {
		logic viaSel;
		logic sccSel;
		cpuWord_t dataIn;
		logic rwN;
		logic udsN;
		logic ldsN;
	} cpuBus_s;

	typedef struct packed {
		volume_t volume;
		logic mute;
		logic alt;
	} soundCtrl_s;

	typedef struct packed {
		logic viaIrqN;
		logic sccIrqN;
	} irqLines_s;

	typedef enum logic [1:0] {
		rsHold,
		rsCount,
		rsRun
	} resetState_e;

endpackage

`default_nettype wire

// File: logic/dataCtrl_defines.svh
`ifndef DATACTRL_DEFINES_SVH
`define DATACTRL_DEFINES_SVH

// clk8 edges that _cpuReset stays low once the system reset lets go
// the real machine holds far longer, any value up to 2^20-1 works
`define RESET_HOLD_CYCLES 16

// VIA register index, taken from A12-A9
`define VIA_REG_ORB 4'd0
`define VIA_REG_ORA 4'd1
`define VIA_REG_IFR 4'd13
`define VIA_REG_IER 4'd14

// SCC register index, taken from A2-A1
`define SCC_REG_STATUS 2'd0
`define SCC_REG_CTRL 2'd1

// low byte on byte-wide peripheral reads
`define BUS_PAD_BYTE 8'hEF

`endif

// File: logic/resetSequencer.sv
`timescale 1ns/1ps
`default_nettype none
`include "dataCtrl_defines.svh"

module resetSequencer import dataCtrlPkg::*; (
	input wire clk8,
	input wire _systemReset,
	output logic cpuResetN
);

	resetState_e state;
	resetCount_t holdCount;

	// edges after release are counted in rsHold and rsCount alike
	always_ff @(posedge clk8 or negedge _systemReset) begin
		if (!_systemReset) begin
			state <= rsHold;
			holdCount <= resetCount_t'(`RESET_HOLD_CYCLES);
			cpuResetN <= 1'b0;
		end else begin
			case (state)
				rsHold, rsCount: begin
					holdCount <= holdCount - 1'b1;
					if (holdCount == resetCount_t'(1)) begin
						state <= rsRun;
						cpuResetN <= 1'b1;
					end else begin
						state <= rsCount;
					end
				end
				default: begin
					state <= rsRun;
					cpuResetN <= 1'b1;
				end
			endcase
		end
	end

	// CPU only leaves reset together with the FSM
	resetOnlyInRun: assert property (@(posedge clk8) cpuResetN |-> state == rsRun)
		else $error("cpuResetN high outside rsRun");

endmodule

`default_nettype wire

// File: logic/sccIrq.sv
`timescale 1ns/1ps
`default_nettype none
`include "dataCtrl_defines.svh"

module sccIrq import dataCtrlPkg::*; (
	input wire clk8,
	input wire cpuResetN,
	input wire cpuBus_s bus,
	input wire sccRegSel_t regSel,
	input wire dcdA,
	input wire dcdB,
	output regByte_t dataOut,
	output logic irqN
);

	logic [1:0] enable;
	logic [1:0] pending;
	logic [1:0] dcdSync1;
	logic [1:0] dcdSync2;
	logic [1:0] dcdSync3;
	logic [1:0] dcdEdge;
	logic sccWrite;
	logic ctrlWrite;
	regByte_t wrData;

	// either strobe will do
	assign sccWrite = bus.sccSel && !bus.rwN && (!bus.udsN || !bus.ldsN);
	assign ctrlWrite = sccWrite && regSel == `SCC_REG_CTRL;
	assign wrData = bus.dataIn[15:8];

	// bit 0 channel A, bit 1 channel B
	always_ff @(posedge clk8 or negedge cpuResetN) begin
		if (!cpuResetN) begin
			dcdSync1 <= 2'b00;
			dcdSync2 <= 2'b00;
			dcdSync3 <= 2'b00;
		end else begin
			dcdSync1 <= {dcdB, dcdA};
			dcdSync2 <= dcdSync1;
			dcdSync3 <= dcdSync2;
		end
	end

	// quadrature lines interrupt on both edges
	assign dcdEdge = dcdSync3 ^ dcdSync2;

	always_ff @(posedge clk8 or negedge cpuResetN) begin
		if (!cpuResetN) begin
			enable <= 2'b00;
			pending <= 2'b00;
		end else begin
			if (ctrlWrite) begin
				enable <= wrData[1:0];
			end
			if (ctrlWrite && wrData[4]) begin
				pending <= dcdEdge & enable;
			end else begin
				pending <= pending | (dcdEdge & enable);
			end
		end
	end

	assign irqN = !(|pending);

	always_comb begin
		case (regSel)
			`SCC_REG_STATUS: dataOut = {2'b00, dcdSync2[1], 1'b0, dcdSync2[0], 1'b0, pending};
			`SCC_REG_CTRL: dataOut = {6'd0, enable};
			default: dataOut = 8'd0;
		endcase
	end

	for (genvar ch = 0; ch < 2; ch++) begin : gChannelCheck
		noPendingWhileMasked: assert property (
			@(posedge clk8) disable iff (!cpuResetN)
			(!enable[ch] && !pending[ch]) |=> !pending[ch]
		) else $error("SCC pending bit %0d set while disabled", ch);
	end

endmodule

`default_nettype wire

// File: logic/soundMixer.sv
`timescale 1ns/1ps
`default_nettype none

module soundMixer import dataCtrlPkg::*; (
	input wire clk8,
	input wire cpuResetN,
	input wire loadSound,
	input wire regByte_t sampleByte,
	input wire soundCtrl_s sound,
	output audioWord_t audioOut,
	output logic sndAlt
);

	regByte_t audioLatch;
	audioWord_t audioX1;
	audioWord_t audioX2;
	audioWord_t audioX4;

	// sample buffer holds unsigned bytes, offset to signed here
	always_ff @(posedge clk8 or negedge cpuResetN) begin
		if (!cpuResetN) begin
			audioLatch <= 8'd0;
		end else if (loadSound) begin
			if (sound.mute) begin
				audioLatch <= 8'd0;
			end else begin
				audioLatch <= sampleByte - 8'd128;
			end
		end
	end

	// x1, x2 and x4 copies, sign extended to the output width
	assign audioX1 = {{3{audioLatch[7]}}, audioLatch};
	assign audioX2 = {{2{audioLatch[7]}}, audioLatch, 1'b0};
	assign audioX4 = {audioLatch[7], audioLatch, 2'b00};

	// volume bits pick which copies go into the sum
	assign audioOut = (sound.volume[0] ? audioX1 : 11'd0)
		+ (sound.volume[1] ? audioX2 : 11'd0)
		+ (sound.volume[2] ? audioX4 : 11'd0);

	assign sndAlt = sound.alt;

endmodule

`default_nettype wire

// File: logic/viaRegs.sv
`timescale 1ns/1ps
`default_nettype none
`include "dataCtrl_defines.svh"

module viaRegs import dataCtrlPkg::*; (
	input wire clk8,
	input wire _systemReset,
	input wire cpuBus_s bus,
	input wire viaRegSel_t regSel,
	input wire _vblank,
	input wire _hblank,
	output cpuWord_t dataOut,
	output logic irqN,
	output soundCtrl_s sound,
	output logic memoryOverlayOn
);

	regByte_t ora;
	regByte_t orb;
	logic [6:0] ifr;
	logic [6:0] ier;
	logic [6:0] ifrClear;
	logic [1:0] blankSync1;
	logic [1:0] blankSync2;
	logic [1:0] blankSync3;
	logic [1:0] blankFall;
	logic viaWrite;
	logic irqActive;
	regByte_t wrData;
	regByte_t ifrRead;
	regByte_t readByte;

	// VIA sits on the upper byte lane
	assign viaWrite = bus.viaSel && !bus.rwN && !bus.udsN;
	assign wrData = bus.dataIn[15:8];

	// bit 1 vblank, bit 0 hblank
	// idle high so release from reset gives no false edge
	always_ff @(posedge clk8 or negedge _systemReset) begin
		if (!_systemReset) begin
			blankSync1 <= 2'b11;
			blankSync2 <= 2'b11;
			blankSync3 <= 2'b11;
		end else begin
			blankSync1 <= {_vblank, _hblank};
			blankSync2 <= blankSync1;
			blankSync3 <= blankSync2;
		end
	end

	assign blankFall = blankSync3 & ~blankSync2;

	// overlay on, volume 0, sound muted at boot
	always_ff @(posedge clk8 or negedge _systemReset) begin
		if (!_systemReset) begin
			ora <= 8'h10;
			orb <= 8'h80;
		end else if (viaWrite) begin
			case (regSel)
				`VIA_REG_ORA: ora <= wrData;
				`VIA_REG_ORB: orb <= wrData;
				default: ;
			endcase
		end
	end

	// ones written to IFR acknowledge those flags
	assign ifrClear = (viaWrite && regSel == `VIA_REG_IFR) ? wrData[6:0] : 7'd0;

	always_ff @(posedge clk8 or negedge _systemReset) begin
		if (!_systemReset) begin
			ifr <= 7'd0;
			ier <= 7'd0;
		end else begin
			// a new edge wins over a clear in the same cycle
			ifr <= (ifr & ~ifrClear) | {5'd0, blankFall};
			if (viaWrite && regSel == `VIA_REG_IER) begin
				if (wrData[7]) begin
					ier <= ier | wrData[6:0];
				end else begin
					ier <= ier & ~wrData[6:0];
				end
			end
		end
	end

	assign irqActive = |(ifr & ier);
	assign irqN = !irqActive;
	assign ifrRead = {irqActive, ifr};

	// IER reads back with bit 7 set, as on the 6522
	always_comb begin
		case (regSel)
			`VIA_REG_ORB: readByte = orb;
			`VIA_REG_ORA: readByte = ora;
			`VIA_REG_IFR: readByte = ifrRead;
			`VIA_REG_IER: readByte = {1'b1, ier};
			default: readByte = 8'd0;
		endcase
	end

	assign dataOut = {readByte, readByte};

	assign sound.volume = ora[2:0];
	assign sound.mute = orb[7];
	assign sound.alt = orb[3];
	assign memoryOverlayOn = ora[4];

	// CPU must always find the source of a VIA request in an IFR read
	irqShownInIfr: assert property (
		@(posedge clk8) disable iff (!_systemReset)
		(!irqN && regSel == `VIA_REG_IFR) |-> (dataOut[15] && dataOut[7])
	) else $error("VIA request without IFR bit 7");

endmodule

`default_nettype wire

// File: verif/tbDataController.sv
`timescale 1ns/1ps
`default_nettype none
`include "dataCtrl_defines.svh"

module tbDataController import dataCtrlPkg::*; ();

	localparam int NUM_VIA = 40;
	localparam int NUM_SND = 40;
	localparam int NUM_BLANK = 16;
	localparam int NUM_MOUSE = 16;
	localparam int NUM_MUX = 40;
	// rough cycles per iteration of each test, reset included
	localparam int SCHEDULED = 4 + NUM_VIA * 3 + NUM_SND * 4 + NUM_BLANK * 10
		+ NUM_MOUSE * 10 + NUM_MUX + 2;
	localparam int CYCLE_LIMIT = 4 * SCHEDULED + `RESET_HOLD_CYCLES;

	logic clk8;
	logic _systemReset;
	cpuWord_t cpuDataIn;
	viaRegSel_t cpuAddrRegHi;
	sccRegSel_t cpuAddrRegLo;
	logic _cpuUDS;
	logic _cpuLDS;
	logic _cpuRW;
	logic selectVIA;
	logic selectSCC;
	logic cpuBusControl;
	cpuWord_t memoryDataIn;
	logic loadSound;
	logic _vblank;
	logic _hblank;
	logic mouseX1;
	logic mouseY1;
	logic _cpuReset;
	ipl_t _cpuIPL;
	cpuWord_t cpuDataOut;
	cpuWord_t memoryDataOut;
	audioWord_t audioOut;
	logic sndAlt;
	logic memoryOverlayOn;

	// model state
	regByte_t mOra;
	regByte_t mOrb;
	logic [6:0] mIfr;
	logic [6:0] mIer;
	logic [1:0] mEn;
	logic [1:0] mPend;
	logic [1:0] mLvl;
	int mLatch;

	integer seed;
	integer i;
	integer k;
	int cycleCount = 0;
	logic [31:0] r;
	logic [1:0] lines;
	viaRegSel_t idx;

	dataController u_dataController (
		.clk8(clk8),
		._systemReset(_systemReset),
		._cpuReset(_cpuReset),
		._cpuIPL(_cpuIPL),
		.cpuDataIn(cpuDataIn),
		.cpuAddrRegHi(cpuAddrRegHi),
		.cpuAddrRegLo(cpuAddrRegLo),
		._cpuUDS(_cpuUDS),
		._cpuLDS(_cpuLDS),
		._cpuRW(_cpuRW),
		.cpuDataOut(cpuDataOut),
		.selectVIA(selectVIA),
		.selectSCC(selectSCC),
		.cpuBusControl(cpuBusControl),
		.memoryDataIn(memoryDataIn),
		.memoryDataOut(memoryDataOut),
		.loadSound(loadSound),
		._vblank(_vblank),
		._hblank(_hblank),
		.mouseX1(mouseX1),
		.mouseY1(mouseY1),
		.audioOut(audioOut),
		.sndAlt(sndAlt),
		.memoryOverlayOn(memoryOverlayOn)
	);

	initial begin
		clk8 = 1'b0;
		forever #5 clk8 = ~clk8;
	end

	always @(posedge clk8) begin
		cycleCount = cycleCount + 1;
		if (cycleCount > CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
			$display("TESTBENCH FAILED");
			$fatal(1, "timeout");
		end
	end

	task automatic reportError(input string msg);
		$display("Error at %0t ns: %s", $time, msg);
		$display("TESTBENCH FAILED");
		$fatal(1, "check failed");
	endtask

	task automatic checkWord(input string what, input cpuWord_t got, input cpuWord_t exp);
		if (got !== exp) begin
			reportError($sformatf("%s is %h, expected %h", what, got, exp));
		end
	endtask

	task automatic checkIpl(input ipl_t got, input ipl_t exp);
		if (got !== exp) begin
			reportError($sformatf("_cpuIPL is %b, expected %b", got, exp));
		end
	endtask

	task automatic checkAudio(input audioWord_t got, input audioWord_t exp);
		if (got !== exp) begin
			reportError($sformatf("audioOut is %h, expected %h", got, exp));
		end
	endtask

	task automatic checkBit(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			reportError($sformatf("%s is %b, expected %b", what, got, exp));
		end
	endtask

	function automatic regByte_t viaByte(input viaRegSel_t sel);
		case (sel)
			`VIA_REG_ORB: return mOrb;
			`VIA_REG_ORA: return mOra;
			`VIA_REG_IFR: return {|(mIfr & mIer), mIfr};
			`VIA_REG_IER: return {1'b1, mIer};
			default: return 8'h00;
		endcase
	endfunction

	function automatic regByte_t sccByte(input sccRegSel_t sel);
		case (sel)
			`SCC_REG_STATUS: return {2'b00, mLvl[1], 1'b0, mLvl[0], 1'b0, mPend};
			`SCC_REG_CTRL: return {6'd0, mEn};
			default: return 8'h00;
		endcase
	endfunction

	// VIA on level 1 wins over SCC on level 2
	function automatic ipl_t expectedIpl();
		if ((mIfr & mIer) != 7'd0) begin
			return 3'b110;
		end else if (mPend != 2'b00) begin
			return 3'b101;
		end
		return 3'b111;
	endfunction

	task automatic checkOutputs();
		cpuWord_t expData;
		regByte_t b;
		if (selectVIA && cpuBusControl) begin
			b = viaByte(cpuAddrRegHi);
			expData = {b, b};
		end else if (selectSCC && cpuBusControl) begin
			expData = {sccByte(cpuAddrRegLo), `BUS_PAD_BYTE};
		end else begin
			expData = memoryDataIn;
		end
		checkWord("cpuDataOut", cpuDataOut, expData);
		checkWord("memoryDataOut", memoryDataOut, cpuDataIn);
		checkIpl(_cpuIPL, expectedIpl());
		checkAudio(audioOut, audioWord_t'(mLatch * int'(mOra[2:0])));
		checkBit("memoryOverlayOn", memoryOverlayOn, mOra[4]);
		checkBit("sndAlt", sndAlt, mOrb[3]);
	endtask

	task automatic busIdle();
		selectVIA = 1'b0;
		selectSCC = 1'b0;
		cpuBusControl = 1'b1;
		_cpuRW = 1'b1;
		_cpuUDS = 1'b1;
		_cpuLDS = 1'b1;
		loadSound = 1'b0;
		cpuDataIn = cpuWord_t'($random(seed));
		memoryDataIn = cpuWord_t'($random(seed));
	endtask

	task automatic tick();
		@(posedge clk8);
		#1;
	endtask

	task automatic settle();
		#1;
		checkOutputs();
	endtask

	// read cycle, both strobes low
	task automatic readBus(input logic via, input logic scc, input viaRegSel_t hi,
		input sccRegSel_t lo);
		@(negedge clk8);
		busIdle();
		selectVIA = via;
		selectSCC = scc;
		cpuAddrRegHi = hi;
		cpuAddrRegLo = lo;
		_cpuUDS = 1'b0;
		_cpuLDS = 1'b0;
	endtask

	task automatic viaWrite(input viaRegSel_t sel, input regByte_t data);
		logic [31:0] pick;
		pick = $random(seed);
		@(negedge clk8);
		busIdle();
		selectVIA = 1'b1;
		cpuAddrRegHi = sel;
		cpuDataIn[15:8] = data;
		_cpuRW = 1'b0;
		_cpuUDS = 1'b0;
		_cpuLDS = pick[0];
		tick();
		case (sel)
			`VIA_REG_ORA: mOra = data;
			`VIA_REG_ORB: mOrb = data;
			`VIA_REG_IFR: mIfr = mIfr & ~data[6:0];
			`VIA_REG_IER: mIer = data[7] ? (mIer | data[6:0]) : (mIer & ~data[6:0]);
			default: ;
		endcase
		checkOutputs();
	endtask

	// either strobe alone should be enough
	task automatic sccWrite(input regByte_t data);
		logic [31:0] pick;
		pick = $random(seed);
		@(negedge clk8);
		busIdle();
		selectSCC = 1'b1;
		cpuAddrRegLo = `SCC_REG_CTRL;
		cpuDataIn[15:8] = data;
		_cpuRW = 1'b0;
		_cpuUDS = pick[0];
		_cpuLDS = !pick[0];
		tick();
		mEn = data[1:0];
		if (data[4]) begin
			mPend = 2'b00;
		end
		checkOutputs();
	endtask

	task automatic loadSample();
		@(negedge clk8);
		busIdle();
		loadSound = 1'b1;
		tick();
		if (mOrb[7]) begin
			mLatch = 0;
		end else begin
			mLatch = int'(memoryDataIn[15:8]) - 128;
		end
		checkOutputs();
	endtask

	initial begin
		seed = 32'h7403_9f7f;
		_systemReset = 1'b0;
		_vblank = 1'b1;
		_hblank = 1'b1;
		mouseX1 = 1'b0;
		mouseY1 = 1'b0;
		cpuAddrRegHi = '0;
		cpuAddrRegLo = '0;
		busIdle();
		// overlay on, volume 0, muted
		mOra = 8'h10;
		mOrb = 8'h80;
		mIfr = '0;
		mIer = '0;
		mEn = '0;
		mPend = '0;
		mLvl = '0;
		mLatch = 0;

		repeat (4) begin
			@(negedge clk8);
			checkBit("_cpuReset", _cpuReset, 1'b0);
		end
		_systemReset = 1'b1;
		for (i = 1; i <= `RESET_HOLD_CYCLES; i++) begin
			tick();
			checkBit("_cpuReset", _cpuReset, i == `RESET_HOLD_CYCLES);
			checkOutputs();
		end

		// register writes and readback, sometimes of another index
		for (i = 0; i < NUM_VIA; i++) begin
			r = $random(seed);
			idx = (r[1:0] == 2'd0) ? `VIA_REG_ORB : (r[1:0] == 2'd1) ? `VIA_REG_ORA : `VIA_REG_IER;
			viaWrite(idx, regByte_t'($random(seed)));
			readBus(1'b1, 1'b0, r[2] ? idx : viaRegSel_t'(r[7:4]), 2'd0);
			settle();
		end

		for (i = 0; i < NUM_SND; i++) begin
			viaWrite(`VIA_REG_ORA, regByte_t'($random(seed)));
			viaWrite(`VIA_REG_ORB, regByte_t'($random(seed)));
			loadSample();
		end

		// blanking edges, bit 1 vblank and bit 0 hblank
		for (i = 0; i < NUM_BLANK; i++) begin
			r = $random(seed);
			viaWrite(`VIA_REG_IER, {r[8], 5'd0, r[1:0]});
			lines = (r[5:4] == 2'b00) ? 2'b01 : r[5:4];
			readBus(1'b1, 1'b0, `VIA_REG_IFR, 2'd0);
			_vblank = !lines[1];
			_hblank = !lines[0];
			settle();
			for (k = 1; k <= 3; k++) begin
				tick();
				if (k == 3) begin
					mIfr[1:0] = mIfr[1:0] | lines;
				end
				checkOutputs();
			end
			readBus(1'b1, 1'b0, `VIA_REG_IFR, 2'd0);
			_vblank = 1'b1;
			_hblank = 1'b1;
			settle();
			repeat (3) begin
				tick();
				checkOutputs();
			end
			viaWrite(`VIA_REG_IFR, {6'd0, r[7:6]});
		end
		viaWrite(`VIA_REG_IFR, 8'h7F);

		// mouse edges, sometimes with a vblank request on top
		for (i = 0; i < NUM_MOUSE; i++) begin
			r = $random(seed);
			sccWrite({3'b000, 1'b1, 2'b00, r[1:0]});
			if (r[2]) begin
				viaWrite(`VIA_REG_IER, 8'h82);
			end
			lines = (r[4:3] == 2'b00) ? 2'b10 : r[4:3];
			readBus(1'b0, 1'b1, 4'd0, `SCC_REG_STATUS);
			mouseX1 = mouseX1 ^ lines[0];
			mouseY1 = mouseY1 ^ lines[1];
			_vblank = !r[2];
			settle();
			for (k = 1; k <= 3; k++) begin
				tick();
				if (k == 2) begin
					mLvl = {mouseY1, mouseX1};
				end
				if (k == 3) begin
					mPend = mPend | (lines & mEn);
					mIfr[1] = mIfr[1] | r[2];
				end
				checkOutputs();
			end
			readBus(1'b0, 1'b1, 4'd0, `SCC_REG_STATUS);
			_vblank = 1'b1;
			settle();
			viaWrite(`VIA_REG_IFR, 8'h7F);
			sccWrite({3'b000, 1'b1, 2'b00, mEn});
		end

		// mux with random selects and bus ownership
		for (i = 0; i < NUM_MUX; i++) begin
			r = $random(seed);
			readBus(r[2:1] == 2'b01, r[2:1] == 2'b10, viaRegSel_t'(r[6:3]), sccRegSel_t'(r[8:7]));
			cpuBusControl = r[0];
			_cpuUDS = r[9];
			_cpuLDS = r[10];
			settle();
		end

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+logic
logic/dataCtrlPkg.sv
logic/resetSequencer.sv
logic/viaRegs.sv
logic/sccIrq.sv
logic/soundMixer.sv
logic/cpuBusCombiner.sv
logic/dataController.sv
verif/tbDataController.sv
